//--- sources.f
+incdir+rtl
rtl/forth_pkg.sv
rtl/tib_scanner.sv
rtl/token_fifo.sv
rtl/dict_rom.sv
rtl/dict_finder.sv
rtl/number_parser.sv
rtl/outer_interp.sv
rtl/forth_outer_top.sv
bench/tb_forth_outer.sv

//--- run_sim.sh
#!/bin/sh
# build the forth front end testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_forth_outer -f sources.f

# dict.hex is read relative to the project root
./obj_dir/Vtb_forth_outer > sim.log
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation clean"

//--- dict.hex
// len (1 digit) | name (16 digits, last char first, unused bytes 0) | xt (4 digits)
// address 0 is the oldest entry, 15 the newest, len 0 marks an empty slot
300000000007075640010
400000000706f72640011
400000000706177730012
4000000007265766f0013
1000000000000002b0020
40000000074696d650021
8746e6174736e6f630030
000000000000000000000
20000000000002b310022
1000000000000002e0023
000000000000000000000
200000000000072630024
3000000000070756400c0
30000000000746f720014
000000000000000000000
3000000000065796200ff

//--- bench/tb_forth_outer.sv
// testbench for the forth front end
// line sender, reference interpreter, result receiver and checker, report
`timescale 1ns/1ps
`include "forth_defs.svh"

module tb_forth_outer;
    import forth_pkg::*;

    localparam int WAIT_LIMIT  = 4000;    // cycles for one handshake edge
    localparam int DRAIN_LIMIT = 8000;    // cycles for the pending results

    logic    clk;
    logic    rst_n;
    logic    cin_req;
    char_t   cin_char;
    logic    cin_ack;
    logic    res_req;
    result_t res;
    logic    res_ack;

    dict_entry_t dict_mem [`FORTH_DICT_DEPTH];   // same image as the ROM
    result_t     exp_q [$];                       // expected results, token order
    integer      seed;
    logic        ack_random;                      // random res_ack delay

    int n_checks;
    int n_errors;
    int n_tokens;
    int n_results;
    int n_tests;
    int tok_mark;     // counters at test start
    int res_mark;
    int err_mark;

    string dict_words [12] = '{"dup", "drop", "swap", "over", "+", "emit",
                               "constant", "1+", ".", "cr", "rot", "bye"};

    forth_outer_top DUT (
        .clk, .rst_n,
        .cin_req, .cin_char, .cin_ack,
        .res_req, .res, .res_ack
    );

    always #50 clk = ~clk;    // 100 ns period

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // token as the scanner should build it
    function automatic token_t make_token(input string s);
        token_t t;
        int     i;
        t          = '0;
        t.too_long = (s.len() > `FORTH_TOK_CHARS);
        t.len      = tok_len_t'(t.too_long ? `FORTH_TOK_CHARS : s.len());
        for (i = 0; (i < s.len()) && (i < `FORTH_TOK_CHARS); i++)
            t.name[i*8 +: 8] = s[i];     // first char lowest byte
        return t;
    endfunction

    // expected result: too long, newest dictionary match, decimal, undefined
    function automatic result_t ref_interpret(input token_t t);
        result_t     r;
        int          i;
        logic        neg;
        logic        seen;
        logic        bad;
        logic [31:0] acc;
        char_t       c;
        r = '0;
        if (t.too_long) begin
            r.kind = RES_LONG;
            return r;
        end
        for (i = `FORTH_DICT_DEPTH - 1; i >= 0; i--) begin
            if ((dict_mem[i].len != 0) && (dict_mem[i].len == t.len) &&
                (dict_mem[i].name == t.name)) begin
                r.kind = RES_EXEC;
                r.xt   = dict_mem[i].xt;
                return r;
            end
        end
        neg  = 1'b0;
        seen = 1'b0;
        bad  = 1'b0;
        acc  = '0;
        for (i = 0; i < int'(t.len); i++) begin
            c = t.name[i*8 +: 8];
            if ((c >= "0") && (c <= "9")) begin
                acc  = acc * 32'd10 + 32'(c - "0");   // wraps at 2^32
                seen = 1'b1;
            end else if ((c == "-") && (i == 0)) begin
                neg = 1'b1;
            end else begin
                bad = 1'b1;
            end
        end
        if (seen && !bad) begin
            r.kind  = RES_PUSH;
            r.value = neg ? -acc : acc;
        end else begin
            r.kind = RES_UNDEF;
        end
        return r;
    endfunction

    task automatic check_kind(input string sig, input res_kind_e exp, input res_kind_e act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %s actual %s", $time, sig, exp.name(), act.name());
        end
    endtask

    task automatic check_xt(input string sig, input xt_t exp, input xt_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, sig, exp, act);
        end
    endtask

    task automatic check_value(input string sig, input cell_t exp, input cell_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %0t %s expected %0d actual %0d", $time, sig, exp, act);
        end
    endtask

    task automatic compare_result(input result_t got);
        result_t e;
        n_results++;
        if (exp_q.size() == 0) begin
            n_errors++;
            $display("%0t: a result arrived while no token was pending", $time);
        end else begin
            e = exp_q.pop_front();
            check_kind("res.kind", e.kind, got.kind);
            check_xt("res.xt", e.xt, got.xt);         // zero unless exec
            check_value("res.value", e.value, got.value);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%0t: %s", $time, why);
        $display("tests %0d, tokens %0d, results %0d, checks %0d, errors %0d",
                 n_tests, n_tokens, n_results, n_checks, n_errors + 1);
        $display("Verification failed");
        $finish;
    endtask

    // one four-phase transfer on cin, entered and left at posedge + 1 ns
    task automatic send_char(input char_t c);
        int n;
        cin_char = c;
        cin_req  = 1'b1;
        n = 0;
        while (!cin_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT)
                abort_run("cin_ack never rose for a character");
        end
        cin_req = 1'b0;
        n = 0;
        while (cin_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT)
                abort_run("cin_ack stayed high after cin_req fell");
        end
    endtask

    // sends a text line, queueing the expected result of each token it closes
    task automatic send_line(input string s);
        string cur;
        int    i;
        cur = "";
        for (i = 0; i < s.len(); i++) begin
            if ((s[i] == 8'h20) || (s[i] == 8'h0A)) begin
                if (cur.len() != 0) begin
                    exp_q.push_back(ref_interpret(make_token(cur)));  // before its delimiter
                    n_tokens++;
                    cur = "";
                end
            end else begin
                cur = $sformatf("%s%c", cur, s[i]);
            end
            send_char(s[i]);
        end
        if (cur.len() != 0) begin
            exp_q.push_back(ref_interpret(make_token(cur)));
            n_tokens++;
            send_char(8'h20);      // close the last token
        end
    endtask

    function automatic string random_word();
        string w;
        int    n;
        int    k;
        w = "";
        case (rand_below(6))
            0: w = dict_words[rand_below(12)];
            1: w = $sformatf("%0d", $random(seed) % 1000);
            2: w = $sformatf("%0d", $random(seed) % 100000000);   // some run long
            3, 4: begin
                n = (rand_below(2) == 0) ? 1 + rand_below(5) : 9 + rand_below(4);
                for (k = 0; k < n; k++)
                    w = $sformatf("%s%c", w, 8'h61 + rand_below(26));
            end
            default: w = $sformatf("%0d%c", rand_below(100), 8'h61 + rand_below(26));
        endcase
        return w;
    endfunction

    task automatic start_test();
        tok_mark = n_tokens;
        res_mark = n_results;
        err_mark = n_errors;
    endtask

    task automatic finish_test(input string name);
        int n;
        int tok;
        int got;
        n = 0;
        while ((exp_q.size() != 0) || res_req || res_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > DRAIN_LIMIT)
                abort_run($sformatf("test %s still has results missing", name));
        end
        tok = n_tokens - tok_mark;
        got = n_results - res_mark;
        if (got != tok) begin
            n_errors++;
            $display("%0t: test %s sent %0d tokens but saw %0d results", $time, name, tok, got);
        end
        n_tests++;
        $display("test %0d %s: %0d tokens, %0d results, %0d errors",
                 n_tests, name, tok, got, n_errors - err_mark);
    endtask

    // result side, acks res and hands it to the checker
    initial begin : res_receiver
        int idle;
        int d;
        int n;
        idle = 0;
        forever begin
            @(posedge clk);
            #1;
            if (res_req && !res_ack) begin
                if (ack_random) begin
                    d = rand_below(6);
                    repeat (d) begin
                        @(posedge clk);
                        #1;
                    end
                end
                compare_result(res);      // res is held while res_req is up
                res_ack = 1'b1;
                n = 0;
                while (res_req) begin
                    @(posedge clk);
                    #1;
                    n++;
                    if (n > WAIT_LIMIT)
                        abort_run("res_req stayed high after res_ack");
                end
                res_ack = 1'b0;
                idle    = 0;
            end else if (exp_q.size() != 0) begin
                idle++;
                if (idle > DRAIN_LIMIT)
                    abort_run("no result came for a pending token");
            end else begin
                idle = 0;
            end
        end
    end

    initial begin
        string line;
        int    b;
        int    i;
        int    d;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cin_req    = 1'b0;
        cin_char   = '0;
        res_ack    = 1'b0;
        ack_random = 1'b0;
        seed       = 43310;
        n_checks   = 0;
        n_errors   = 0;
        n_tokens   = 0;
        n_results  = 0;
        n_tests    = 0;
        $readmemh("dict.hex", dict_mem);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // every name once, then dup again, which must give the newer xt
        start_test();
        send_line("dup drop swap over + emit constant 1+ . cr rot bye dup ");
        finish_test("dictionary words");

        // eight digits stay below 2^32, so the largest values sit at the top
        start_test();
        send_line("0 7 42 -1 -0 007 123456 -1234567 99999999 12345678 2147483 ");
        finish_test("decimal numbers");

        start_test();
        send_line("- 1a 12x foo dupx du --1 1- -a 3.5 ");
        finish_test("malformed tokens");

        // 8 chars still looked up, 9 and more rejected
        start_test();
        send_line("constant abcdefgh 87654321 constants 123456789 -12345678 ");
        send_line("abcdefghijklmnop dupdupdup ");
        finish_test("long tokens");

        start_test();
        send_line("\n  dup\n\n 42 \n-7   \n\nfoo \n \n swap\n");
        send_line("    \n\n  rot\n\n\n");
        finish_test("delimiter runs");

        // random words, random delimiter runs, random res_ack delay
        ack_random = 1'b1;
        for (b = 1; b <= 2; b++) begin
            start_test();
            line = "";
            for (i = 0; i < 40; i++) begin
                line = {line, random_word()};
                d = 1 + rand_below(3);
                repeat (d) begin
                    if (rand_below(3) == 0)
                        line = {line, "\n"};
                    else
                        line = {line, " "};
                end
            end
            send_line(line);
            finish_test($sformatf("random burst %0d", b));
        end
        ack_random = 1'b0;

        $display("tests %0d, tokens %0d, results %0d, checks %0d, errors %0d",
                 n_tests, n_tokens, n_results, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- rtl/forth_outer_top.sv
// forth front end top
// scanner -> token FIFO -> outer interpreter, plus the dictionary ROM
`timescale 1ns/1ps
`include "forth_defs.svh"

module forth_outer_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cin_req,
    input  forth_pkg::char_t    cin_char,
    output logic                cin_ack,
    output logic                res_req,
    output forth_pkg::result_t  res,
    input  logic                res_ack
);
    import forth_pkg::*;

    logic        push_req, push_ack;   // scanner to FIFO
    token_t      push_tok;
    logic        pop_req, pop_ack;     // FIFO to interpreter
    token_t      pop_tok;
    dict_addr_t  rom_addr;             // finder read port
    dict_entry_t rom_entry;

    tib_scanner u_scanner (
        .clk, .rst_n,
        .cin_req, .cin_char, .cin_ack,
        .push_req, .push_tok, .push_ack
    );

    token_fifo #(
        .DEPTH (`FORTH_FIFO_DEPTH)
    ) u_fifo (
        .clk, .rst_n,
        .push_req, .push_tok, .push_ack,
        .pop_req, .pop_tok, .pop_ack
    );

    outer_interp u_interp (
        .clk, .rst_n,
        .pop_req, .pop_tok, .pop_ack,
        .res_req, .res, .res_ack,
        .rom_addr, .rom_entry
    );

    dict_rom u_rom (
        .clk,
        .rom_addr, .rom_entry
    );

endmodule

//--- rtl/outer_interp.sv
// outer interpreter
// pops tokens, runs find then number parse, sends one result per token
`timescale 1ns/1ps

module outer_interp (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pop_req,
    input  forth_pkg::token_t      pop_tok,
    output logic                   pop_ack,
    output logic                   res_req,
    output forth_pkg::result_t     res,
    input  logic                   res_ack,
    output forth_pkg::dict_addr_t  rom_addr,
    input  forth_pkg::dict_entry_t rom_entry
);
    import forth_pkg::*;

    outer_state_e state;
    outer_state_e state_d;
    token_t       tok_q;       // token being interpreted
    logic         take;        // new token offered
    logic         fnd_en, fnd_bsy, fnd_hit, fnd_done;
    xt_t          fnd_xt;
    logic         num_en, num_bsy, num_ok, num_done;
    cell_t        num_value;

    assign take     = pop_req && !pop_ack;
    // en is a one-cycle pulse, bsy rises the cycle after it
    assign fnd_done = !fnd_en && !fnd_bsy;
    assign num_done = !num_en && !num_bsy;

    dict_finder u_finder (
        .clk, .rst_n,
        .en        (fnd_en),
        .tok       (tok_q),
        .bsy       (fnd_bsy),
        .hit       (fnd_hit),
        .xt        (fnd_xt),
        .rom_addr  (rom_addr),
        .rom_entry (rom_entry)
    );

    number_parser u_parser (
        .clk, .rst_n,
        .en    (num_en),
        .tok   (tok_q),
        .bsy   (num_bsy),
        .ok    (num_ok),
        .value (num_value)
    );

    always_comb begin
        state_d = state;
        case (state)
            O_IDLE:  if (take)     state_d = pop_tok.too_long ? O_EMIT : O_FIND;
            O_FIND:  if (fnd_done) state_d = fnd_hit ? O_EMIT : O_PARSE;
            O_PARSE: if (num_done) state_d = O_EMIT;
            O_EMIT:  if (res_ack)  state_d = O_DONE;
            O_DONE:  if (!res_ack) state_d = O_IDLE;   // res back at rest
            default: state_d = O_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= O_IDLE;
            pop_ack <= 1'b0;
            res_req <= 1'b0;
            fnd_en  <= 1'b0;
            num_en  <= 1'b0;
        end else begin
            state  <= state_d;
            fnd_en <= (state == O_IDLE) && (state_d == O_FIND);
            num_en <= (state == O_FIND) && (state_d == O_PARSE);

            if ((state == O_IDLE) && take)
                pop_ack <= 1'b1;
            else if (pop_ack && !pop_req)
                pop_ack <= 1'b0;

            if ((state != O_EMIT) && (state_d == O_EMIT))
                res_req <= 1'b1;                // res loads on the same edge
            else if ((state == O_EMIT) && res_ack)
                res_req <= 1'b0;
        end
    end

    // token and result payload
    always_ff @(posedge clk) begin
        case (state)
            O_IDLE: if (take) begin
                tok_q <= pop_tok;
                if (pop_tok.too_long)
                    res <= '{kind: RES_LONG, xt: '0, value: '0};
            end
            O_FIND: if (fnd_done && fnd_hit)
                res <= '{kind: RES_EXEC, xt: fnd_xt, value: '0};
            O_PARSE: if (num_done) begin
                if (num_ok)
                    res <= '{kind: RES_PUSH, xt: '0, value: num_value};
                else
                    res <= '{kind: RES_UNDEF, xt: '0, value: '0};
            end
            default: ;
        endcase
    end

    a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
        res_req |=> !res_req || $stable(res));

endmodule

//--- rtl/number_parser.sv
// signed decimal parser
// one char per cycle plus a finishing cycle, wraps modulo 2^32
`timescale 1ns/1ps

module number_parser (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  forth_pkg::token_t tok,
    output logic              bsy,
    output logic              ok,
    output forth_pkg::cell_t  value
);
    import forth_pkg::*;

    tok_len_t idx;        // char position
    char_t    ch;         // char at idx
    logic     is_digit;
    logic     neg;        // leading minus seen
    logic     seen;       // at least one digit
    logic     bad;        // any char that is not allowed
    cell_t    acc;

    assign ch       = tok.name[{idx[2:0], 3'b000} +: 8];
    assign is_digit = (ch >= 8'h30) && (ch <= 8'h39);     // '0'..'9'

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bsy   <= 1'b0;
            ok    <= 1'b0;
            value <= '0;
            idx   <= '0;
            neg   <= 1'b0;
            seen  <= 1'b0;
            bad   <= 1'b0;
            acc   <= '0;
        end else if (!bsy) begin
            if (en) begin
                bsy  <= 1'b1;
                ok   <= 1'b0;
                idx  <= '0;
                neg  <= 1'b0;
                seen <= 1'b0;
                bad  <= 1'b0;
                acc  <= '0;
            end
        end else if (idx < tok.len) begin
            idx <= idx + 1'b1;
            if (is_digit) begin
                // acc*10 + digit, upper bits fall off
                acc  <= (acc <<< 3) + (acc <<< 1) + cell_t'(ch - 8'h30);
                seen <= 1'b1;
            end else if ((ch == 8'h2D) && (idx == '0)) begin
                neg <= 1'b1;              // minus only in front
            end else begin
                bad <= 1'b1;
            end
        end else begin
            bsy   <= 1'b0;
            ok    <= seen && !bad;
            value <= neg ? -acc : acc;
        end
    end

endmodule

//--- rtl/dict_finder.sv
// dictionary finder
// walks the ROM from the newest entry down and matches length and name
`timescale 1ns/1ps
`include "forth_defs.svh"

module dict_finder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  forth_pkg::token_t      tok,
    output logic                   bsy,
    output logic                   hit,
    output forth_pkg::xt_t         xt,
    output forth_pkg::dict_addr_t  rom_addr,
    input  forth_pkg::dict_entry_t rom_entry
);
    import forth_pkg::*;

    dict_addr_t addr;     // entry under test
    logic       phase;    // 0 rom read in flight, 1 entry valid
    logic       match;

    assign rom_addr = addr;

    // empty slots have len 0 and never match
    assign match = (rom_entry.len != '0) &&
                   (rom_entry.len == tok.len) &&
                   (rom_entry.name == tok.name);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bsy   <= 1'b0;
            hit   <= 1'b0;
            xt    <= '0;
            addr  <= '0;
            phase <= 1'b0;
        end else if (!bsy) begin
            if (en) begin
                bsy   <= 1'b1;
                hit   <= 1'b0;
                xt    <= '0;
                addr  <= dict_addr_t'(`FORTH_DICT_DEPTH - 1);   // newest first
                phase <= 1'b0;
            end
        end else if (!phase) begin
            phase <= 1'b1;                // rom samples addr on this edge
        end else if (match) begin
            bsy <= 1'b0;                  // first match wins
            hit <= 1'b1;
            xt  <= rom_entry.xt;
        end else if (addr == '0) begin
            bsy <= 1'b0;                  // oldest entry checked, miss
        end else begin
            addr  <= addr - 1'b1;
            phase <= 1'b0;
        end
    end

endmodule

//--- rtl/dict_rom.sv
// dictionary ROM, registered read, contents from dict.hex
`timescale 1ns/1ps
`include "forth_defs.svh"

module dict_rom (
    input  logic                   clk,
    input  forth_pkg::dict_addr_t  rom_addr,
    output forth_pkg::dict_entry_t rom_entry
);
    import forth_pkg::*;

    // higher address = newer definition
    dict_entry_t rom [`FORTH_DICT_DEPTH];

    initial begin
        $readmemh("dict.hex", rom);   // one 21-digit entry per line
    end

    // data shows up one cycle after the address
    always_ff @(posedge clk) begin
        rom_entry <= rom[rom_addr];
    end

endmodule

//--- rtl/token_fifo.sv
// token FIFO
// circular buffer with a four-phase push side and a four-phase pop side
`timescale 1ns/1ps
`include "forth_defs.svh"

module token_fifo #(
    parameter int DEPTH = `FORTH_FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push_req,
    input  forth_pkg::token_t push_tok,
    output logic              push_ack,
    output logic              pop_req,
    output forth_pkg::token_t pop_tok,
    input  logic              pop_ack
);
    import forth_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    token_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;     // tokens stored
    logic             full;
    logic             wr_en;     // push accepted this cycle
    logic             rd_en;     // head taken by the interpreter

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;   // wrap for any depth
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign wr_en   = push_req && !push_ack && !full;
    assign rd_en   = pop_req && pop_ack;
    assign pop_tok = mem[rd_ptr];     // head slot, untouched until rd_en

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= push_tok;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            push_ack <= 1'b0;
            pop_req  <= 1'b0;
        end else begin
            // push sequencer, ack held low while full
            if (wr_en) begin
                wr_ptr   <= ptr_inc(wr_ptr);
                push_ack <= 1'b1;
            end else if (push_ack && !push_req) begin
                push_ack <= 1'b0;
            end

            // pop sequencer, next req only after ack has fallen
            if (rd_en) begin
                rd_ptr  <= ptr_inc(rd_ptr);
                pop_req <= 1'b0;
            end else if (!pop_req && !pop_ack && (count != '0)) begin
                pop_req <= 1'b1;
            end

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(push_ack) |-> $past(count) != CNT_W'(DEPTH));

endmodule

//--- rtl/tib_scanner.sv
// character scanner
// cuts the input stream into whitespace-delimited tokens and pushes them out
`timescale 1ns/1ps
`include "forth_defs.svh"

module tib_scanner (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cin_req,
    input  forth_pkg::char_t  cin_char,
    output logic              cin_ack,
    output logic              push_req,
    output forth_pkg::token_t push_tok,
    input  logic              push_ack
);
    import forth_pkg::*;

    token_t     cur;          // token under assembly
    logic       is_delim;     // space or newline
    logic       push_idle;    // push link back at rest
    logic       ends_tok;     // delimiter closes a non-empty token
    logic       take;         // char accepted this cycle
    logic [5:0] wr_bit;       // bit offset of next char in name

    assign is_delim  = (cin_char == 8'h20) || (cin_char == 8'h0A);
    assign push_idle = !push_req && !push_ack;
    assign ends_tok  = is_delim && (cur.len != '0);
    // closing delimiter waits for a free push link, that is the back pressure
    assign take      = cin_req && !cin_ack && (!ends_tok || push_idle);
    assign wr_bit    = {cur.len[2:0], 3'b000};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cin_ack  <= 1'b0;
            push_req <= 1'b0;
            cur      <= '0;
        end else begin
            if (take) begin
                cin_ack <= 1'b1;
                if (ends_tok) begin
                    push_req <= 1'b1;           // ack and req rise together
                    cur      <= '0;             // unused bytes must read zero
                end else if (!is_delim) begin
                    if (cur.len < tok_len_t'(`FORTH_TOK_CHARS)) begin
                        cur.name[wr_bit +: 8] <= cin_char;
                        cur.len               <= cur.len + 1'b1;
                    end else begin
                        cur.too_long <= 1'b1;   // ninth char onward is dropped
                    end
                end
                // extra delimiters between tokens are just acked
            end else if (cin_ack && !cin_req) begin
                cin_ack <= 1'b0;                // phase 4 on cin
            end

            if (push_req && push_ack)
                push_req <= 1'b0;               // FIFO took it
        end
    end

    // outgoing token, held for the whole push handshake
    always_ff @(posedge clk) begin
        if (take && ends_tok)
            push_tok <= cur;
    end

    a_push_tok_stable: assert property (@(posedge clk) disable iff (!rst_n)
        push_req |=> !push_req || $stable(push_tok));

endmodule

//--- rtl/forth_pkg.sv
// shared types of the forth front end
// vector typedefs, token/dictionary/result structs, result and FSM enums
`include "forth_defs.svh"

package forth_pkg;

    typedef logic [`FORTH_CHAR_W-1:0]        char_t;       // one character
    typedef logic [`FORTH_LEN_W-1:0]         tok_len_t;    // 1..8 in a real token
    typedef logic [`FORTH_XT_W-1:0]          xt_t;         // execution token
    typedef logic signed [`FORTH_CELL_W-1:0] cell_t;       // data cell
    typedef logic [`FORTH_DICT_AW-1:0]       dict_addr_t;  // rom address

    // first char in the lowest byte, unused bytes zero
    typedef logic [`FORTH_TOK_CHARS*`FORTH_CHAR_W-1:0] name_t;

    typedef struct packed {
        tok_len_t len;        // stored chars, saturates at 8
        logic     too_long;   // more than 8 chars were seen
        name_t    name;
    } token_t;

    // one line of dict.hex, len zero marks an empty slot
    typedef struct packed {
        tok_len_t len;
        name_t    name;
        xt_t      xt;
    } dict_entry_t;

    typedef enum logic [1:0] {
        RES_EXEC  = 2'd0,   // dictionary word
        RES_PUSH  = 2'd1,   // number
        RES_UNDEF = 2'd2,
        RES_LONG  = 2'd3    // token over 8 chars
    } res_kind_e;

    typedef struct packed {
        res_kind_e kind;
        xt_t       xt;      // RES_EXEC only
        cell_t     value;   // RES_PUSH only
    } result_t;

    typedef enum logic [2:0] {
        O_IDLE, O_FIND, O_PARSE, O_EMIT, O_DONE
    } outer_state_e;

endpackage

//--- rtl/forth_defs.svh
// sizes and widths of the forth front end
// token length, dictionary depth, FIFO depth and datapath widths
`ifndef FORTH_DEFS_SVH
`define FORTH_DEFS_SVH

// token buffer
`define FORTH_TOK_CHARS  8      // max chars stored per token
`define FORTH_CHAR_W     8      // one ascii char
`define FORTH_LEN_W      4      // holds 0..8

// dictionary
`define FORTH_DICT_DEPTH 16     // rom entries
`define FORTH_DICT_AW    4      // rom address width
`define FORTH_XT_W       16     // execution token

// FIFO between scanner and interpreter
`define FORTH_FIFO_DEPTH 4

// data cell
`define FORTH_CELL_W     32

`endif // FORTH_DEFS_SVH
